// File: src/hspi_pkg.sv
`default_nettype none

package hspi_pkg;

	// link and RAM sizes
	localparam int word_w = 32;
	localparam int ram_aw = 6;
	localparam int frame_words = 16;
	localparam int cnt_w = $clog2(frame_words);
	localparam int seq_w = 4;
	localparam int len_w = 2;
	localparam int udf_w = 26;

	// RAM regions
	localparam logic [ram_aw-1:0] tx_base = 6'd0;
	localparam logic [ram_aw-1:0] rx_base = 6'd32;

	// header fields
	localparam logic [udf_w-1:0] hdr_udf = 26'h0F0F0F;
	localparam logic [len_w-1:0] hdr_len_tag = len_w'(frame_words * 4 - 1);

	// CRC-32, register kept in reflected form
	localparam logic [word_w-1:0] crc_init = '1;
	localparam logic [word_w-1:0] crc_poly = 32'hEDB88320;
	localparam logic [word_w-1:0] crc_residue = 32'hC704DD7B; // normal bit order

	// one link word, raw or as header
	typedef union packed {
		logic [word_w-1:0] raw;
		struct packed {
			logic [len_w-1:0] len_tag;
			logic [seq_w-1:0] seq;
			logic [udf_w-1:0] udf;
		} fld;
	} hspi_word_u;

	typedef enum logic [2:0] {
		st_idle,
		st_wait_rdy,
		st_header,
		st_data,
		st_crc
	} tx_state_e;

endpackage

`default_nettype wire

// File: src/crc32_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_lfsr (
	input wire clk,
	input wire wire_rst,
	input wire clr,
	input wire en,
	input wire [hspi_pkg::word_w-1:0] data,
	output logic [hspi_pkg::word_w-1:0] crc
);

	logic [hspi_pkg::word_w-1:0] crc_nxt;

	// whole word per cycle, bit 0 enters first
	always_comb begin
		crc_nxt = crc;
		for (int i = 0; i < hspi_pkg::word_w; i++) begin
			if (crc_nxt[0] ^ data[i])
				crc_nxt = (crc_nxt >> 1) ^ hspi_pkg::crc_poly;
			else
				crc_nxt = crc_nxt >> 1;
		end
	end

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst)
			crc <= hspi_pkg::crc_init;
		else if (clr)
			crc <= hspi_pkg::crc_init; // new frame
		else if (en)
			crc <= crc_nxt;
	end

endmodule

`default_nettype wire

// File: src/hspi_tx.sv
`timescale 1ns/1ps
`default_nettype none

module hspi_tx (
	input wire clk,
	input wire wire_rst,
	input wire tx_act,
	input wire hract,
	input wire htrdy,
	output logic htreq,
	output logic htvld,
	output logic htoe,
	output logic [hspi_pkg::word_w-1:0] htd,
	output logic tx_idle,
	output logic rd_en,
	output logic [hspi_pkg::ram_aw-1:0] rd_addr,
	input wire [hspi_pkg::word_w-1:0] rd_data
);

	hspi_pkg::tx_state_e state;
	logic act_q;
	logic act_d;
	logic act_pend;
	logic hract_q;
	logic rdy_q;
	logic start;
	logic word_out;
	logic tail;
	logic last_word;
	logic [hspi_pkg::cnt_w-1:0] cnt;
	logic [hspi_pkg::seq_w-1:0] tx_seq;
	hspi_pkg::hspi_word_u hdr_word;
	logic [hspi_pkg::word_w-1:0] sel_word;
	logic [hspi_pkg::word_w-1:0] crc;
	logic crc_clr;
	logic crc_en;

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst) begin
			act_q <= 1'b0;
			act_d <= 1'b0;
			hract_q <= 1'b0;
			rdy_q <= 1'b0;
		end else begin
			act_q <= tx_act;
			act_d <= act_q;
			hract_q <= hract;
			rdy_q <= htrdy; // FSM state is the second stage
		end
	end

	// hold a trigger until the link is free
	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst)
			act_pend <= 1'b0;
		else if (act_q && !act_d)
			act_pend <= 1'b1;
		else if (start)
			act_pend <= 1'b0;
	end

	assign tx_idle = (state == hspi_pkg::st_idle) && !htreq;
	assign start = tx_idle && act_pend && !hract && !hract_q;
	assign word_out = (state == hspi_pkg::st_header) || (state == hspi_pkg::st_data) ||
			(state == hspi_pkg::st_crc);
	assign tail = (state == hspi_pkg::st_idle) && htvld; // crc word on the link
	assign last_word = cnt == hspi_pkg::cnt_w'(hspi_pkg::frame_words - 1);

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst) begin
			state <= hspi_pkg::st_idle;
		end else begin
			case (state)
				hspi_pkg::st_idle:
					if (start)
						state <= hspi_pkg::st_wait_rdy;
				hspi_pkg::st_wait_rdy:
					if (rdy_q)
						state <= hspi_pkg::st_header;
				hspi_pkg::st_header:
					state <= hspi_pkg::st_data;
				hspi_pkg::st_data:
					if (last_word)
						state <= hspi_pkg::st_crc;
				default:
					state <= hspi_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst)
			cnt <= '0;
		else if (state == hspi_pkg::st_header)
			cnt <= '0;
		else if (state == hspi_pkg::st_data)
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst)
			tx_seq <= '0;
		else if (state == hspi_pkg::st_crc)
			tx_seq <= tx_seq + 1'b1;
	end

	// reads run one address ahead of the output register
	assign rd_en = (state == hspi_pkg::st_header) ||
			((state == hspi_pkg::st_data) && !last_word);
	assign rd_addr = hspi_pkg::tx_base + ((state == hspi_pkg::st_data) ?
			hspi_pkg::ram_aw'(cnt) + 1'b1 : '0);

	always_comb begin
		hdr_word.fld.len_tag = hspi_pkg::hdr_len_tag;
		hdr_word.fld.seq = tx_seq;
		hdr_word.fld.udf = hspi_pkg::hdr_udf;
	end

	always_comb begin
		case (state)
			hspi_pkg::st_header: sel_word = hdr_word.raw;
			hspi_pkg::st_crc: sel_word = ~crc;
			default: sel_word = rd_data;
		endcase
	end

	assign crc_clr = state == hspi_pkg::st_wait_rdy;
	assign crc_en = (state == hspi_pkg::st_header) || (state == hspi_pkg::st_data);

	crc32_lfsr i_crc (
		.clk(clk),
		.wire_rst(wire_rst),
		.clr(crc_clr),
		.en(crc_en),
		.data(sel_word),
		.crc(crc)
	);

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst) begin
			htreq <= 1'b0;
			htvld <= 1'b0;
			htoe <= 1'b0;
		end else begin
			htvld <= word_out;
			if (start)
				htreq <= 1'b1;
			else if (tail)
				htreq <= 1'b0;
			if (state == hspi_pkg::st_header)
				htoe <= 1'b1; // drive from header on
			else if (tail)
				htoe <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		htd <= sel_word;
	end

	a_vld_in_oe: assert property (@(posedge clk) disable iff (wire_rst)
		$rose(htvld) |-> htoe && htreq);

	a_data_len: assert property (@(posedge clk) disable iff (wire_rst)
		state == hspi_pkg::st_header |=>
			(state == hspi_pkg::st_data) [*hspi_pkg::frame_words] ##1
			state == hspi_pkg::st_crc);

endmodule

`default_nettype wire

// File: src/hspi_rx.sv
`timescale 1ns/1ps
`default_nettype none

module hspi_rx (
	input wire clk,
	input wire wire_rst,
	input wire hract,
	input wire hrvld,
	input wire [hspi_pkg::word_w-1:0] hrd,
	input wire tx_idle,
	output logic htack,
	output logic wr_en,
	output logic [hspi_pkg::ram_aw-1:0] wr_addr,
	output logic [hspi_pkg::word_w-1:0] wr_data,
	output logic crc_err,
	output logic seq_err,
	output logic [hspi_pkg::seq_w-1:0] rx_seq
);

	logic hract_q;
	logic hract_d;
	logic hrvld_q;
	logic [hspi_pkg::word_w-1:0] hrd_q;
	hspi_pkg::hspi_word_u rx_word;
	logic start;
	logic done;
	logic chk_q;
	logic word_in;
	logic hdr_seen;
	logic is_hdr;
	logic [hspi_pkg::cnt_w:0] idx;
	logic [hspi_pkg::seq_w-1:0] got_seq;
	logic [hspi_pkg::word_w-1:0] crc;
	logic [hspi_pkg::word_w-1:0] crc_rev;

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst) begin
			hract_q <= 1'b0;
			hract_d <= 1'b0;
			hrvld_q <= 1'b0;
			chk_q <= 1'b0;
		end else begin
			hract_q <= hract;
			hract_d <= hract_q;
			hrvld_q <= hrvld;
			chk_q <= done;
		end
	end

	always_ff @(posedge clk) begin
		hrd_q <= hrd;
	end

	assign start = hract && !hract_q; // clears one cycle before the first word
	assign done = hract_d && !hract_q;
	assign word_in = hrvld_q && hract_q;
	assign is_hdr = word_in && !hdr_seen;
	assign rx_word.raw = hrd_q;

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst) begin
			hdr_seen <= 1'b0;
			got_seq <= '0;
		end else if (start) begin
			hdr_seen <= 1'b0;
		end else if (is_hdr) begin
			hdr_seen <= 1'b1;
			got_seq <= rx_word.fld.seq;
		end
	end

	// payload words after the header, crc word is not stored
	assign wr_en = word_in && hdr_seen && (idx < hspi_pkg::frame_words);
	assign wr_addr = hspi_pkg::rx_base + hspi_pkg::ram_aw'(idx[hspi_pkg::cnt_w-1:0]);
	assign wr_data = hrd_q;

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst)
			idx <= '0;
		else if (start)
			idx <= '0;
		else if (wr_en)
			idx <= idx + 1'b1;
	end

	crc32_lfsr i_crc (
		.clk(clk),
		.wire_rst(wire_rst),
		.clr(start),
		.en(word_in),
		.data(hrd_q),
		.crc(crc)
	);

	assign crc_rev = {<<{crc}};

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst) begin
			crc_err <= 1'b0;
			seq_err <= 1'b0;
		end else if (start) begin
			crc_err <= 1'b0;
			seq_err <= 1'b0;
		end else if (done) begin
			crc_err <= crc_rev != hspi_pkg::crc_residue;
			seq_err <= got_seq != rx_seq;
		end
	end

	// count only clean frames
	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst)
			rx_seq <= '0;
		else if (chk_q && !crc_err && !seq_err)
			rx_seq <= rx_seq + 1'b1;
	end

	always_ff @(posedge clk or posedge wire_rst) begin
		if (wire_rst)
			htack <= 1'b0;
		else if (htack && !hract_q)
			htack <= 1'b0;
		else if (!htack && hract_q && tx_idle)
			htack <= 1'b1; // peer may send now
	end

	a_wr_count: assert property (@(posedge clk) disable iff (wire_rst)
		(start ##1 wr_en [->hspi_pkg::frame_words]) |=> !wr_en until start);

endmodule

`default_nettype wire

// File: src/hspi_top.sv
`timescale 1ns/1ps
`default_nettype none

module hspi_top (
	input wire clk,
	input wire wire_rst,
	input wire tx_act,
	input wire htrdy,
	output wire htreq,
	output wire htvld,
	output wire htoe,
	output wire [hspi_pkg::word_w-1:0] htd,
	input wire hract,
	input wire hrvld,
	input wire [hspi_pkg::word_w-1:0] hrd,
	output wire htack,
	output wire crc_err,
	output wire seq_err,
	output wire [hspi_pkg::seq_w-1:0] rx_seq,
	output wire ram_csn,
	output wire ram_wen,
	output wire [hspi_pkg::ram_aw-1:0] ram_addr,
	output wire [hspi_pkg::word_w-1:0] ram_wdata,
	input wire [hspi_pkg::word_w-1:0] ram_rdata
);

	wire tx_idle;
	wire rd_en;
	wire [hspi_pkg::ram_aw-1:0] rd_addr;
	wire wr_en;
	wire [hspi_pkg::ram_aw-1:0] wr_addr;
	wire [hspi_pkg::word_w-1:0] wr_data;

	hspi_tx i_hspi_tx (
		.clk(clk),
		.wire_rst(wire_rst),
		.tx_act(tx_act),
		.hract(hract),
		.htrdy(htrdy),
		.htreq(htreq),
		.htvld(htvld),
		.htoe(htoe),
		.htd(htd),
		.tx_idle(tx_idle),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(ram_rdata)
	);

	hspi_rx i_hspi_rx (
		.clk(clk),
		.wire_rst(wire_rst),
		.hract(hract),
		.hrvld(hrvld),
		.hrd(hrd),
		.tx_idle(tx_idle),
		.htack(htack),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.crc_err(crc_err),
		.seq_err(seq_err),
		.rx_seq(rx_seq)
	);

	// transmit owns the port only while reading
	assign ram_csn = !(rd_en || wr_en);
	assign ram_wen = !(wr_en && !rd_en);
	assign ram_addr = rd_en ? rd_addr : wr_addr;
	assign ram_wdata = wr_data;

	a_ram_excl: assert property (@(posedge clk) disable iff (wire_rst)
		!(rd_en && wr_en));

endmodule

`default_nettype wire

// File: verif/hspi_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module hspi_clk_gen (
	output logic clk,
	output logic wire_rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		wire_rst = 1'b1;
		repeat (10) @(posedge clk);
		wire_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verif/hspi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hspi_tb;

	typedef struct packed {
		logic is_rx;
		logic block_tx; // tx_act edge while receiving
		logic [4:0] reps;
		logic [hspi_pkg::seq_w-1:0] seq;
		logic corrupt;
		logic [3:0] bad_idx;
		logic exp_crc_err;
		logic exp_seq_err;
		logic [hspi_pkg::seq_w-1:0] exp_rx_seq;
	} frame_entry_t;

	localparam int n_entries = 7;

	wire clk;
	wire wire_rst;
	logic tx_act;
	logic htrdy;
	logic hract;
	logic hrvld;
	logic [hspi_pkg::word_w-1:0] hrd;
	wire htreq;
	wire htvld;
	wire htoe;
	wire [hspi_pkg::word_w-1:0] htd;
	wire htack;
	wire crc_err;
	wire seq_err;
	wire [hspi_pkg::seq_w-1:0] rx_seq;
	wire ram_csn;
	wire ram_wen;
	wire [hspi_pkg::ram_aw-1:0] ram_addr;
	wire [hspi_pkg::word_w-1:0] ram_wdata;
	logic [hspi_pkg::word_w-1:0] ram_rdata = '0;

	logic [hspi_pkg::word_w-1:0] mem [0:(1 << hspi_pkg::ram_aw)-1];
	frame_entry_t frames [n_entries];
	integer seed;
	int cycles = 0;
	int cycle_limit = 0;
	int total_frames;
	logic [hspi_pkg::seq_w-1:0] tx_seq_exp;
	hspi_pkg::tx_state_e tx_state;

	hspi_clk_gen i_hspi_clk_gen (
		.clk(clk),
		.wire_rst(wire_rst)
	);

	hspi_top i_hspi_top (
		.clk(clk), .wire_rst(wire_rst), .tx_act(tx_act), .htrdy(htrdy),
		.htreq(htreq), .htvld(htvld), .htoe(htoe), .htd(htd),
		.hract(hract), .hrvld(hrvld), .hrd(hrd), .htack(htack),
		.crc_err(crc_err), .seq_err(seq_err), .rx_seq(rx_seq),
		.ram_csn(ram_csn), .ram_wen(ram_wen), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
	);

	assign tx_state = i_hspi_top.i_hspi_tx.state;

	// RAM model with one cycle read latency
	always @(posedge clk) begin
		if (!ram_csn) begin
			if (!ram_wen)
				mem[ram_addr] <= ram_wdata;
			else
				ram_rdata <= mem[ram_addr];
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, transmit FSM in %s", cycles, tx_state.name());
			$display("*** TEST FAILED ***");
			$fatal(1, "simulation did not finish in time");
		end
	end

	task automatic check_word(input string name, input logic [hspi_pkg::word_w-1:0] got,
			input logic [hspi_pkg::word_w-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_seq(input string name, input logic [hspi_pkg::seq_w-1:0] got,
			input logic [hspi_pkg::seq_w-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "sequence mismatch");
		end
	endtask

	// reflected CRC-32 over one word with bit 0 first
	function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input logic [31:0] d);
		logic [31:0] poly_n;
		logic [31:0] poly_r;
		logic [31:0] c;
		logic fb;
		poly_n = 32'h04C11DB7;
		for (int i = 0; i < 32; i++)
			poly_r[i] = poly_n[31-i];
		c = crc_in;
		for (int i = 0; i < 32; i++) begin
			fb = c[0] ^ d[i];
			c = c >> 1;
			if (fb)
				c = c ^ poly_r;
		end
		return c;
	endfunction

	function automatic logic [31:0] header_word(input logic [hspi_pkg::seq_w-1:0] seq);
		return {hspi_pkg::hdr_len_tag, seq, hspi_pkg::hdr_udf}; // length tag on top
	endfunction

	task automatic expect_reset_state();
		check_bit("htreq", htreq, 1'b0);
		check_bit("htvld", htvld, 1'b0);
		check_bit("htoe", htoe, 1'b0);
		check_bit("htack", htack, 1'b0);
		check_bit("crc_err", crc_err, 1'b0);
		check_bit("seq_err", seq_err, 1'b0);
		check_bit("ram_csn", ram_csn, 1'b1);
		check_bit("ram_wen", ram_wen, 1'b1);
		check_seq("rx_seq", rx_seq, '0);
	endtask

	task automatic pulse_tx_act();
		@(posedge clk);
		tx_act <= 1'b1;
		@(posedge clk);
		tx_act <= 1'b0;
	endtask

	task automatic capture_tx_frame(input logic pulse);
		logic [31:0] crc;
		logic [31:0] exp;
		if (pulse)
			pulse_tx_act();
		@(negedge clk);
		while (!htreq)
			@(negedge clk);
		@(posedge clk);
		htrdy <= 1'b1;
		@(negedge clk);
		while (!htvld)
			@(negedge clk);
		crc = '1;
		for (int i = 0; i < hspi_pkg::frame_words + 2; i++) begin
			if (i == 0)
				exp = header_word(tx_seq_exp);
			else if (i <= hspi_pkg::frame_words)
				exp = mem[hspi_pkg::tx_base + i - 1];
			else
				exp = ~crc; // complemented register
			check_bit("htvld", htvld, 1'b1);
			check_bit("htoe", htoe, 1'b1);
			check_bit("htreq", htreq, 1'b1);
			check_word($sformatf("htd[%0d]", i), htd, exp);
			crc = crc_update(crc, exp);
			@(negedge clk);
		end
		check_bit("htvld", htvld, 1'b0);
		check_bit("htoe", htoe, 1'b0);
		check_bit("htreq", htreq, 1'b0);
		@(posedge clk);
		htrdy <= 1'b0;
		tx_seq_exp = tx_seq_exp + 1'b1;
	endtask

	task automatic send_rx_frame(input frame_entry_t e);
		logic [31:0] words [hspi_pkg::frame_words+2];
		logic [31:0] crc;
		int n;
		n = hspi_pkg::frame_words;
		words[0] = header_word(e.seq);
		crc = crc_update('1, words[0]);
		for (int i = 1; i <= n; i++) begin
			words[i] = $random(seed);
			crc = crc_update(crc, words[i]);
		end
		words[n+1] = ~crc;
		if (e.corrupt)
			words[e.bad_idx + 1] = words[e.bad_idx + 1] ^ 32'h0000_0100;
		@(posedge clk);
		hract <= 1'b1;
		repeat (3) @(negedge clk);
		check_bit("htack", htack, 1'b1);
		if (e.block_tx)
			pulse_tx_act();
		for (int i = 0; i < n + 2; i++) begin
			@(posedge clk);
			hrvld <= 1'b1;
			hrd <= words[i];
		end
		@(posedge clk);
		hrvld <= 1'b0;
		hrd <= '0;
		@(negedge clk);
		check_bit("htreq", htreq, 1'b0); // held off by hract
		@(posedge clk);
		hract <= 1'b0;
		repeat (4) @(negedge clk);
		check_bit("htack", htack, 1'b0);
		check_bit("crc_err", crc_err, e.exp_crc_err);
		check_bit("seq_err", seq_err, e.exp_seq_err);
		check_seq("rx_seq", rx_seq, e.exp_rx_seq);
		for (int i = 0; i < n; i++)
			check_word($sformatf("ram[%0d]", hspi_pkg::rx_base + i),
				mem[hspi_pkg::rx_base + i], words[i+1]);
		if (e.block_tx)
			capture_tx_frame(1'b0); // deferred request
	endtask

	initial begin
		tx_act = 1'b0;
		htrdy = 1'b0;
		hract = 1'b0;
		hrvld = 1'b0;
		hrd = '0;
		tx_seq_exp = '0;
		seed = 60079;
		frames[0] = '{1'b0, 1'b0, 5'd3, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0};
		frames[1] = '{1'b1, 1'b0, 5'd1, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd1};
		frames[2] = '{1'b1, 1'b0, 5'd1, 4'd1, 1'b1, 4'd5, 1'b1, 1'b0, 4'd1};
		frames[3] = '{1'b1, 1'b0, 5'd1, 4'd7, 1'b0, 4'd0, 1'b0, 1'b1, 4'd1};
		frames[4] = '{1'b1, 1'b1, 5'd1, 4'd1, 1'b0, 4'd0, 1'b0, 1'b0, 4'd2};
		frames[5] = '{1'b0, 1'b0, 5'd14, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd2};
		frames[6] = '{1'b1, 1'b0, 5'd1, 4'd2, 1'b0, 4'd0, 1'b0, 1'b0, 4'd3};
		for (int a = 0; a < (1 << hspi_pkg::ram_aw); a++)
			mem[a] = $random(seed);
		total_frames = 0;
		for (int e = 0; e < n_entries; e++)
			total_frames += frames[e].reps * (frames[e].block_tx ? 2 : 1);
		cycle_limit = total_frames * (hspi_pkg::frame_words + 40) + 100 + 10;
		@(negedge clk);
		expect_reset_state();
		while (wire_rst)
			@(negedge clk);
		expect_reset_state();
		for (int e = 0; e < n_entries; e++) begin
			for (int r = 0; r < frames[e].reps; r++) begin
				if (frames[e].is_rx)
					send_rx_frame(frames[e]);
				else
					capture_tx_frame(1'b1);
			end
			check_seq("rx_seq", rx_seq, frames[e].exp_rx_seq);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: hspi.f
src/hspi_pkg.sv
src/crc32_lfsr.sv
src/hspi_tx.sv
src/hspi_rx.sv
src/hspi_top.sv
verif/hspi_clk_gen.sv
verif/hspi_tb.sv
